// File: include/led_consts.svh
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// panel geometry
`define PANEL_COLUMNS 8
`define PIXELS_PER_COLUMN 16

// pixel address covers PANEL_COLUMNS * PIXELS_PER_COLUMN words
`define PIX_ADDR_BITS 7

// one driver word, three 10-bit channels
`define DRV_WORD_BITS 30

// clk cycles per serial/greyscale tick
`define CLK_EN_DIV 4

// blanking between columns, in enable ticks
`define BLANKING_TIME 72

`endif

// File: verilog/led_pixel_pkg.sv
package led_pixel_pkg;

    // pixel as stored in memory
    typedef logic [4:0] red5_t;
    typedef logic [5:0] green6_t;
    typedef logic [4:0] blue5_t;

    typedef struct packed {
        red5_t   red;
        green6_t green;
        blue5_t  blue;
    } rgb565_t;

    // one channel of a constant-current driver
    typedef logic [9:0] drv_chan_t;

    // word shifted into the driver chain, red goes out first
    typedef struct packed {
        drv_chan_t red;
        drv_chan_t green;
        drv_chan_t blue;
    } drv_word_t;

endpackage

// File: verilog/led_ctrl_pkg.sv
package led_ctrl_pkg;

    // test pattern selection
    // the shift modes rotate the red/green/blue sequence along the address
    typedef enum logic [1:0] {
        PAT_SHIFT0 = 2'd0,
        PAT_SHIFT1 = 2'd1,
        PAT_SHIFT2 = 2'd2,
        PAT_WHITE  = 2'd3
    } pattern_mode_t;

    // driver controller FSM
    typedef enum logic [2:0] {
        CTRL_IDLE  = 3'd0,
        CTRL_SHIFT = 3'd1,
        CTRL_LATCH = 3'd2,
        CTRL_BLANK = 3'd3
    } ctrl_state_t;

endpackage

// File: verilog/clock_enable.sv
`include "led_consts.svh"

module clock_enable (
    input  logic clk,
    input  logic nrst,
    output logic clk_en
);

    localparam int CNT_BITS = $clog2(`CLK_EN_DIV);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`CLK_EN_DIV - 1);

    logic [CNT_BITS-1:0] count;

    // pulse on wrap, first one CLK_EN_DIV cycles out of reset
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count  <= '0;
            clk_en <= 1'b0;
        end else begin
            if (count == CNT_LAST) begin
                count  <= '0;
                clk_en <= 1'b1;
            end else begin
                count  <= count + 1'b1;
                clk_en <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/pattern_ram.sv
`include "led_consts.svh"

module pattern_ram (
    input  logic                        clk,
    input  logic                        nrst,
    input  led_ctrl_pkg::pattern_mode_t mode,
    input  logic [`PIX_ADDR_BITS-1:0]   pix_addr,
    output led_pixel_pkg::rgb565_t      pixel
);

    localparam led_pixel_pkg::rgb565_t PIX_RED   = '{red: 5'd16, green: 6'd0,  blue: 5'd0};
    localparam led_pixel_pkg::rgb565_t PIX_GREEN = '{red: 5'd0,  green: 6'd48, blue: 5'd0};
    localparam led_pixel_pkg::rgb565_t PIX_BLUE  = '{red: 5'd0,  green: 6'd0,  blue: 5'd16};
    localparam led_pixel_pkg::rgb565_t PIX_WHITE = '{red: 5'd4,  green: 6'd4,  blue: 5'd4};

    logic [1:0] residue;
    logic [1:0] shift;
    logic [2:0] sum;
    logic [1:0] k;

    // colour index = (addr mod 3 + shift) mod 3
    always_comb begin
        residue = 2'(pix_addr % 3);
        shift   = mode;
        sum     = {1'b0, residue} + {1'b0, shift};
        k       = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
    end

    // one cycle read latency, like a block RAM
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pixel <= '0;
        end else if (mode == led_ctrl_pkg::PAT_WHITE) begin
            pixel <= PIX_WHITE;
        end else begin
            case (k)
                2'd0:    pixel <= PIX_RED;
                2'd1:    pixel <= PIX_GREEN;
                default: pixel <= PIX_BLUE;
            endcase
        end
    end

endmodule

// File: verilog/framebuffer.sv
`include "led_consts.svh"

module framebuffer (
    input  logic                      clk,
    input  logic                      nrst,
    input  led_pixel_pkg::rgb565_t    pixel,
    input  logic                      word_taken,
    output logic [`PIX_ADDR_BITS-1:0] pix_addr,
    output led_pixel_pkg::drv_word_t  word,
    output logic                      word_valid
);

    localparam int ADDR_BITS  = `PIX_ADDR_BITS;
    localparam int NUM_PIXELS = `PANEL_COLUMNS * `PIXELS_PER_COLUMN;
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = ADDR_BITS'(NUM_PIXELS - 1);

    // address out, data back, word held for the controller
    typedef enum logic [1:0] {
        FB_ADDR,
        FB_DATA,
        FB_HOLD
    } fetch_state_t;

    fetch_state_t             fetch_state;
    led_pixel_pkg::drv_word_t widened;

    // replicate MSBs to fill the 10-bit channels
    always_comb begin
        widened.red   = {pixel.red, pixel.red};
        widened.green = {pixel.green, pixel.green[5:2]};
        widened.blue  = {pixel.blue, pixel.blue};
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fetch_state <= FB_ADDR;
            pix_addr    <= '0;
            word_valid  <= 1'b0;
        end else begin
            case (fetch_state)
                FB_ADDR: fetch_state <= FB_DATA;
                FB_DATA: begin
                    fetch_state <= FB_HOLD;
                    word_valid  <= 1'b1;
                end
                FB_HOLD: begin
                    // hold until consumed, then go for the next pixel
                    if (word_taken) begin
                        word_valid  <= 1'b0;
                        fetch_state <= FB_ADDR;
                        pix_addr    <= (pix_addr == LAST_ADDR) ? '0 : pix_addr + 1'b1;
                    end
                end
                default: fetch_state <= FB_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_state == FB_DATA) begin
            word <= widened;
        end
    end

endmodule

// File: verilog/driver_controller.sv
`include "led_consts.svh"

module driver_controller (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     clk_en,
    input  led_pixel_pkg::drv_word_t word,
    input  logic                     word_valid,
    output logic                     word_taken,
    output logic                     sin,
    output logic                     sclk,
    output logic                     lat,
    output logic                     gclk,
    output logic                     column_step
);

    localparam int BIT_CNT_BITS   = $clog2(`DRV_WORD_BITS);
    localparam int WORD_CNT_BITS  = $clog2(`PIXELS_PER_COLUMN);
    localparam int BLANK_CNT_BITS = $clog2(`BLANKING_TIME);

    localparam logic [BIT_CNT_BITS-1:0]   LAST_BIT   = BIT_CNT_BITS'(`DRV_WORD_BITS - 1);
    localparam logic [WORD_CNT_BITS-1:0]  LAST_WORD  = WORD_CNT_BITS'(`PIXELS_PER_COLUMN - 1);
    localparam logic [BLANK_CNT_BITS-1:0] LAST_BLANK = BLANK_CNT_BITS'(`BLANKING_TIME - 1);

    led_ctrl_pkg::ctrl_state_t state;

    logic [`DRV_WORD_BITS-1:0] shift_reg;
    logic [BIT_CNT_BITS-1:0]   bit_cnt;
    logic [WORD_CNT_BITS-1:0]  word_cnt;
    logic [BLANK_CNT_BITS-1:0] blank_cnt;
    logic                      bit_strobe;
    logic                      column_done;

    // this latch is the last one of the column
    assign column_done = (word_cnt == LAST_WORD);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= led_ctrl_pkg::CTRL_IDLE;
            bit_cnt     <= '0;
            word_cnt    <= '0;
            blank_cnt   <= '0;
            bit_strobe  <= 1'b0;
            sin         <= 1'b0;
            sclk        <= 1'b0;
            lat         <= 1'b0;
            gclk        <= 1'b0;
            word_taken  <= 1'b0;
            column_step <= 1'b0;
        end else begin
            word_taken  <= 1'b0;
            lat         <= 1'b0;
            column_step <= 1'b0;
            bit_strobe  <= 1'b0;
            // sclk trails the data change by one cycle
            sclk        <= bit_strobe;

            if (clk_en) begin
                // greyscale clock parked low through the blanking period
                if (state == led_ctrl_pkg::CTRL_BLANK ||
                    (state == led_ctrl_pkg::CTRL_LATCH && column_done)) begin
                    gclk <= 1'b0;
                end else begin
                    gclk <= ~gclk;
                end

                case (state)
                    led_ctrl_pkg::CTRL_IDLE: begin
                        if (word_valid) begin
                            word_taken <= 1'b1;
                            bit_cnt    <= '0;
                            state      <= led_ctrl_pkg::CTRL_SHIFT;
                        end
                    end
                    led_ctrl_pkg::CTRL_SHIFT: begin
                        sin        <= shift_reg[`DRV_WORD_BITS-1];
                        bit_strobe <= 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= led_ctrl_pkg::CTRL_LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    led_ctrl_pkg::CTRL_LATCH: begin
                        lat <= 1'b1;
                        if (column_done) begin
                            word_cnt  <= '0;
                            blank_cnt <= '0;
                            state     <= led_ctrl_pkg::CTRL_BLANK;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= led_ctrl_pkg::CTRL_IDLE;
                        end
                    end
                    led_ctrl_pkg::CTRL_BLANK: begin
                        if (blank_cnt == LAST_BLANK) begin
                            column_step <= 1'b1;
                            state       <= led_ctrl_pkg::CTRL_IDLE;
                        end else begin
                            blank_cnt <= blank_cnt + 1'b1;
                        end
                    end
                    default: state <= led_ctrl_pkg::CTRL_IDLE;
                endcase
            end
        end
    end

    // serial data, MSB first
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (state == led_ctrl_pkg::CTRL_IDLE && word_valid) begin
                shift_reg <= word;
            end else if (state == led_ctrl_pkg::CTRL_SHIFT) begin
                shift_reg <= {shift_reg[`DRV_WORD_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

// File: verilog/column_mux.sv
`include "led_consts.svh"

module column_mux (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      column_step,
    output logic [`PANEL_COLUMNS-1:0] mux_out
);

    localparam int COLS = `PANEL_COLUMNS;

    // column 0 selected out of reset
    localparam logic [COLS-1:0] FIRST_COLUMN = COLS'(1);

    // one-hot, rotates left and wraps back to column 0
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mux_out <= FIRST_COLUMN;
        end else if (column_step) begin
            mux_out <= {mux_out[COLS-2:0], mux_out[COLS-1]};
        end
    end

endmodule

// File: verilog/led_panel_top.sv
`include "led_consts.svh"

module led_panel_top (
    input  logic                        clk,
    input  logic                        nrst,
    input  led_ctrl_pkg::pattern_mode_t pattern_mode,
    output logic                        sin,
    output logic                        sclk,
    output logic                        lat,
    output logic                        gclk,
    output logic [`PANEL_COLUMNS-1:0]   mux_out
);

    logic                      clk_en;
    logic [`PIX_ADDR_BITS-1:0] pix_addr;
    led_pixel_pkg::rgb565_t    pixel;
    led_pixel_pkg::drv_word_t  word;
    logic                      word_valid;
    logic                      word_taken;
    logic                      column_step;

    // serial and greyscale tick
    clock_enable u_clock_enable (
        .clk    (clk),
        .nrst   (nrst),
        .clk_en (clk_en)
    );

    // stands in for pixel memory
    pattern_ram u_pattern_ram (
        .clk      (clk),
        .nrst     (nrst),
        .mode     (pattern_mode),
        .pix_addr (pix_addr),
        .pixel    (pixel)
    );

    framebuffer u_framebuffer (
        .clk        (clk),
        .nrst       (nrst),
        .pixel      (pixel),
        .word_taken (word_taken),
        .pix_addr   (pix_addr),
        .word       (word),
        .word_valid (word_valid)
    );

    driver_controller u_driver_controller (
        .clk         (clk),
        .nrst        (nrst),
        .clk_en      (clk_en),
        .word        (word),
        .word_valid  (word_valid),
        .word_taken  (word_taken),
        .sin         (sin),
        .sclk        (sclk),
        .lat         (lat),
        .gclk        (gclk),
        .column_step (column_step)
    );

    column_mux u_column_mux (
        .clk         (clk),
        .nrst        (nrst),
        .column_step (column_step),
        .mux_out     (mux_out)
    );

endmodule

// File: test/led_panel_props.sv
`include "led_consts.svh"

module led_panel_props (
    input logic                      clk,
    input logic                      nrst,
    input logic                      sclk,
    input logic                      lat,
    input logic                      gclk,
    input logic [`PANEL_COLUMNS-1:0] mux_out
);

    localparam int LAT_CNT_BITS = $clog2(`PIXELS_PER_COLUMN);
    localparam logic [LAT_CNT_BITS-1:0] LAST_LAT = LAT_CNT_BITS'(`PIXELS_PER_COLUMN - 1);

    logic [LAT_CNT_BITS-1:0]   lat_cnt;
    logic [`PANEL_COLUMNS-1:0] mux_q;
    logic                      blank_window;

    // open after the last lat of a column, closed by the mux step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lat_cnt      <= '0;
            mux_q        <= `PANEL_COLUMNS'(1);
            blank_window <= 1'b0;
        end else begin
            mux_q <= mux_out;
            if (lat) begin
                lat_cnt <= (lat_cnt == LAST_LAT) ? '0 : lat_cnt + 1'b1;
            end
            if (lat && lat_cnt == LAST_LAT) begin
                blank_window <= 1'b1;
            end else if (mux_out != mux_q) begin
                blank_window <= 1'b0;
            end
        end
    end

    a_lat_sclk_apart: assert property (@(posedge clk) disable iff (!nrst) !(lat && sclk))
        else $error("lat and sclk high together");

    a_mux_onehot: assert property (@(posedge clk) disable iff (!nrst) $onehot(mux_out))
        else $error("mux_out is not one-hot");

    a_gclk_quiet: assert property (@(posedge clk) disable iff (!nrst)
        blank_window |-> $stable(gclk))
        else $error("gclk moved during column blanking");

endmodule

bind led_panel_top led_panel_props u_props (
    .clk     (clk),
    .nrst    (nrst),
    .sclk    (sclk),
    .lat     (lat),
    .gclk    (gclk),
    .mux_out (mux_out)
);

// File: test/led_panel_tb.sv
`include "led_consts.svh"

module led_panel_tb;

    localparam int NUM_LINES      = 5;
    localparam int MEM_ADDR_BITS  = $clog2(NUM_LINES * 4);
    localparam int WORDS_PER_LINE = 2 * `PIXELS_PER_COLUMN;
    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = NUM_LINES * (WORDS_PER_LINE * (`DRV_WORD_BITS + 4)
                                    * `CLK_EN_DIV + 2 * `BLANKING_TIME * `CLK_EN_DIV) + 1000;

    logic                        clk;
    logic                        nrst;
    led_ctrl_pkg::pattern_mode_t pattern_mode;
    logic                        sin;
    logic                        sclk;
    logic                        lat;
    logic                        gclk;
    logic [`PANEL_COLUMNS-1:0]   mux_out;

    // per line the mode and then expected words for residues 0 to 2
    logic [31:0]              pat_mem [0:NUM_LINES*4-1];
    led_pixel_pkg::drv_word_t exp_words [0:2];

    // state of the output monitor
    logic [`DRV_WORD_BITS-1:0] cap_word;
    logic [1:0]                residue;
    logic                      gclk_prev;
    logic [`PANEL_COLUMNS-1:0] mux_prev;
    logic                      blanking;
    int                        bit_count;
    int                        lat_count;
    int                        col_steps;
    int                        gclk_edges;

    int word_errors     = 0;
    int protocol_errors = 0;
    int line_errors     = 0;
    int cycle_count     = 0;

    led_panel_top uut (
        .clk          (clk),
        .nrst         (nrst),
        .pattern_mode (pattern_mode),
        .sin          (sin),
        .sclk         (sclk),
        .lat          (lat),
        .gclk         (gclk),
        .mux_out      (mux_out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d word, %0d protocol, %0d line",
                     word_errors, protocol_errors, line_errors);
            $display("Something failed");
            $finish;
        end
    end

    // outputs change on posedge and are sampled on negedge
    always @(negedge clk) begin
        if (!nrst) begin
            cap_word   = '0;
            bit_count  = 0;
            lat_count  = 0;
            col_steps  = 0;
            gclk_edges = 0;
            blanking   = 1'b0;
        end else begin
            if (gclk != gclk_prev) begin
                if (blanking) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: gclk edge during column blanking", $time);
                end else begin
                    gclk_edges++;
                end
            end
            if (mux_out != mux_prev) begin
                if (!blanking) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: mux_out moved before the last lat of the column",
                             $time);
                end else if (mux_out != {mux_prev[`PANEL_COLUMNS-2:0],
                                         mux_prev[`PANEL_COLUMNS-1]}) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: mux_out is %b after %b", $time, mux_out, mux_prev);
                end
                blanking = 1'b0;
                col_steps++;
            end
            if (sclk) begin
                if (blanking || lat) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: sclk pulse during blanking or lat", $time);
                end
                cap_word = {cap_word[`DRV_WORD_BITS-2:0], sin};
                bit_count++;
            end
            if (lat) begin
                residue = 2'(lat_count % 3);
                if (blanking) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: lat %0d came before the mux_out step",
                             $time, lat_count);
                end
                if (bit_count != `DRV_WORD_BITS) begin
                    protocol_errors++;
                    $display("[FAIL] %0t: %0d sclk pulses before lat %0d",
                             $time, bit_count, lat_count);
                end
                if (lat_count < WORDS_PER_LINE && cap_word != exp_words[residue]) begin
                    word_errors++;
                    $display("[FAIL] %0t: word %0d is %h, expected %h (mode %0d)",
                             $time, lat_count, cap_word, exp_words[residue], pattern_mode);
                end
                bit_count = 0;
                lat_count++;
                if (lat_count % `PIXELS_PER_COLUMN == 0) begin
                    blanking = 1'b1;
                end
            end
        end
        gclk_prev = gclk;
        mux_prev  = mux_out;
    end

    // load one pattern line under reset and wait for two full columns
    task automatic run_line(input int idx);
        @(posedge clk);
        #DRIVE_DELAY;
        nrst         = 1'b0;
        pattern_mode = led_ctrl_pkg::pattern_mode_t'(pat_mem[MEM_ADDR_BITS'(idx * 4)][1:0]);
        exp_words[0] = pat_mem[MEM_ADDR_BITS'(idx * 4 + 1)][`DRV_WORD_BITS-1:0];
        exp_words[1] = pat_mem[MEM_ADDR_BITS'(idx * 4 + 2)][`DRV_WORD_BITS-1:0];
        exp_words[2] = pat_mem[MEM_ADDR_BITS'(idx * 4 + 3)][`DRV_WORD_BITS-1:0];
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        if (sin || sclk || lat || gclk || mux_out != `PANEL_COLUMNS'(1)) begin
            line_errors++;
            $display("[FAIL] %0t: outputs not in reset state in line %0d", $time, idx);
        end
        nrst = 1'b1;
        do @(posedge clk); while (lat_count < WORDS_PER_LINE || col_steps < 2);
        if (gclk_edges == 0) begin
            line_errors++;
            $display("[FAIL] %0t: no gclk edges in line %0d", $time, idx);
        end
    endtask

    initial begin
        int line_idx;
        clk          = 1'b0;
        nrst         = 1'b0;
        pattern_mode = led_ctrl_pkg::PAT_SHIFT0;
        $readmemh("test/led_patterns.txt", pat_mem);
        for (line_idx = 0; line_idx < NUM_LINES; line_idx++) begin
            run_line(line_idx);
        end
        $display("errors: %0d word, %0d protocol, %0d line",
                 word_errors, protocol_errors, line_errors);
        if (word_errors + protocol_errors + line_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: test/led_patterns.txt
// columns: mode, expected word for address mod 3 = 0, 1, 2
// words are {red, green, blue} with 10 bits per channel
0 21000000 000C3000 00000210
1 000C3000 00000210 21000000
2 00000210 21000000 000C3000
3 08410484 08410484 08410484
0 21000000 000C3000 00000210

// File: all.f
+incdir+include
verilog/led_pixel_pkg.sv
verilog/led_ctrl_pkg.sv
verilog/clock_enable.sv
verilog/pattern_ram.sv
verilog/framebuffer.sv
verilog/driver_controller.sv
verilog/column_mux.sv
verilog/led_panel_top.sv
test/led_panel_props.sv
test/led_panel_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module led_panel_tb -f all.f \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vled_panel_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
